// ==== cnn_cfg.svh ====
`ifndef CNN_CFG_SVH
`define CNN_CFG_SVH

// Pixel and DDR word geometry
`define PIX_W          8
`define PIX_PER_WORD   8
`define DDR_DATA_W     64
`define DDR_ADDR_W     32     // Word address
`define LEN_W          16

// Line bank sizing, line length is 1 to 16 words
`define LINE_WORDS_W   5
`define BANK_DEPTH     16

`define ACC_W          24
`define BIAS_W         16
`define KERNEL_WORDS   2      // Nine weights over two words

// Instruction word layout
`define INST_W         64
`define INST_OP_HI     63
`define INST_OP_LO     62
`define INST_BIAS_HI   55
`define INST_BIAS_LO   40
`define INST_LW_HI     36
`define INST_LW_LO     32
`define INST_ADDR_HI   31
`define INST_ADDR_LO   0

`endif

// ==== cnn_ctrl_pkg.sv ====
`include "cnn_cfg.svh"

package cnn_ctrl_pkg;

	// Instruction opcodes
	typedef enum logic [`INST_OP_HI-`INST_OP_LO:0] {
		OP_NOP    = 2'd0,
		OP_LOAD_W = 2'd1,   // Kernel load
		OP_LOAD_F = 2'd2,   // Three feature lines
		OP_CONV   = 2'd3
	} opcode_e;

	typedef enum logic {
		TGT_KERNEL,
		TGT_LINES
	} fetch_target_e;

	typedef enum logic [1:0] {
		DEC_IDLE,
		DEC_FETCH,   // Waiting on fetch done
		DEC_SCAN     // Waiting on scan done
	} dec_state_e;

	typedef enum logic [1:0] {
		FET_IDLE,
		FET_READ,
		FET_UNPACK   // Kernel bytes of the held word
	} fetch_state_e;

	typedef enum logic {
		SCAN_IDLE,
		SCAN_RUN
	} scan_state_e;

endpackage

// ==== cnn_data_pkg.sv ====
`include "cnn_cfg.svh"

package cnn_data_pkg;

	typedef logic        [`PIX_W-1:0]        pixel_t;   // Feature pixel, unsigned
	typedef logic signed [`PIX_W-1:0]        weight_t;
	typedef logic        [`DDR_DATA_W-1:0]   ddr_word_t;
	typedef logic        [`DDR_ADDR_W-1:0]   ddr_addr_t;
	typedef logic        [`LEN_W-1:0]        len_t;

	// Word address inside one line bank
	typedef logic [$clog2(`BANK_DEPTH)-1:0]                 bank_addr_t;
	// Pixel column across a full line
	typedef logic [$clog2(`BANK_DEPTH*`PIX_PER_WORD)-1:0]   col_t;
	typedef logic [`LINE_WORDS_W-1:0]                       line_words_t;

	typedef logic signed [`ACC_W-1:0]   acc_t;
	typedef logic signed [`BIAS_W-1:0]  bias_t;
	typedef logic        [`INST_W-1:0]  inst_t;

endpackage

// ==== cnn_if.sv ====
`timescale 1ns/1ps
`include "cnn_cfg.svh"

// Load command from the decoder to the DDR fetch unit
interface fetch_cmd_if;
	logic                          start;      // One cycle
	cnn_ctrl_pkg::fetch_target_e   target;
	cnn_data_pkg::ddr_addr_t       ddr_addr;
	cnn_data_pkg::line_words_t     line_words;
	logic                          done;       // Last word consumed

	modport ctrl (
		output start, target, ddr_addr, line_words,
		input  done
	);

	modport unit (
		input  start, target, ddr_addr, line_words,
		output done
	);
endinterface

// Line bank write port
interface buf_wr_if;
	logic                      we;
	logic [1:0]                bank;   // 0 to 2
	cnn_data_pkg::bank_addr_t  addr;
	cnn_data_pkg::ddr_word_t   data;

	modport src (output we, bank, addr, data);
	modport dst (input  we, bank, addr, data);
endinterface

// ==== cnn_top.sv ====
`timescale 1ns/1ps

module cnn_top (
	input  logic                     clk,
	input  logic                     rst_n,
	input  cnn_data_pkg::inst_t      instruct,
	input  logic                     inst_empty,
	output logic                     inst_req,
	output logic                     ddr_conf,
	output cnn_data_pkg::ddr_addr_t  ddr_st_addr,
	output cnn_data_pkg::len_t       ddr_len,
	input  logic                     ddr_fifo_empty,
	output logic                     ddr_fifo_req,
	input  cnn_data_pkg::ddr_word_t  ddr_fifo_data,
	output cnn_data_pkg::acc_t       result,
	output logic                     result_valid,
	output logic                     idle
);

	cnn_data_pkg::line_words_t  line_words;
	cnn_data_pkg::bias_t        bias;
	logic                       scan_start;
	logic                       scan_done;
	cnn_data_pkg::bank_addr_t   rd_addr;
	cnn_data_pkg::ddr_word_t    rd_data [3];
	logic                       win_valid;
	cnn_data_pkg::pixel_t       window [9];
	logic                       kernel_we;
	logic [3:0]                 kernel_idx;
	cnn_data_pkg::weight_t      kernel_byte;

	fetch_cmd_if u_fetch_if ();
	buf_wr_if    u_wr_if ();

	inst_decoder u_inst_decoder (
		.clk(clk), .rst_n(rst_n),
		.instruct(instruct), .inst_empty(inst_empty), .inst_req(inst_req),
		.idle(idle), .fetch(u_fetch_if.ctrl),
		.scan_start(scan_start), .scan_done(scan_done),
		.line_words(line_words), .bias(bias)
	);

	ddr_fetch u_ddr_fetch (
		.clk(clk), .rst_n(rst_n), .cmd(u_fetch_if.unit),
		.ddr_conf(ddr_conf), .ddr_st_addr(ddr_st_addr), .ddr_len(ddr_len),
		.ddr_fifo_empty(ddr_fifo_empty), .ddr_fifo_req(ddr_fifo_req),
		.ddr_fifo_data(ddr_fifo_data), .wr(u_wr_if.src),
		.kernel_we(kernel_we), .kernel_idx(kernel_idx), .kernel_byte(kernel_byte)
	);

	feature_buffer u_feature_buffer (
		.clk(clk), .wr(u_wr_if.dst), .rd_addr(rd_addr), .rd_data(rd_data)
	);

	window_scanner u_window_scanner (
		.clk(clk), .rst_n(rst_n), .scan_start(scan_start), .line_words(line_words),
		.rd_addr(rd_addr), .rd_data(rd_data),
		.win_valid(win_valid), .window(window), .scan_done(scan_done)
	);

	conv_pe u_conv_pe (
		.clk(clk), .rst_n(rst_n),
		.kernel_we(kernel_we), .kernel_idx(kernel_idx), .kernel_byte(kernel_byte),
		.bias(bias), .win_valid(win_valid), .window(window),
		.result(result), .result_valid(result_valid)
	);

endmodule

// ==== conv_pe.sv ====
`timescale 1ns/1ps
`include "cnn_cfg.svh"

module conv_pe (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   kernel_we,
	input  logic [3:0]             kernel_idx,
	input  cnn_data_pkg::weight_t  kernel_byte,
	input  cnn_data_pkg::bias_t    bias,
	input  logic                   win_valid,
	input  cnn_data_pkg::pixel_t   window [9],
	output cnn_data_pkg::acc_t     result,
	output logic                   result_valid
);

	localparam int PROD_W = 2*`PIX_W + 1;   // Unsigned pixel times signed weight

	cnn_data_pkg::weight_t      kernel [9];
	logic signed [PROD_W-1:0]   prod [9];
	cnn_data_pkg::acc_t         sum;
	logic                       s1_valid;

	always_ff @(posedge clk) begin
		if (kernel_we)
			kernel[kernel_idx] <= kernel_byte;
	end

	//////////////////////////////
	// Stage 1, nine products
	always_ff @(posedge clk) begin
		for (int i = 0; i < 9; i++)
			prod[i] <= $signed({1'b0, window[i]}) * kernel[i];
	end

	// Adder tree plus sign-extended bias
	always_comb begin
		sum = cnn_data_pkg::acc_t'(bias);
		for (int i = 0; i < 9; i++)
			sum = sum + cnn_data_pkg::acc_t'(prod[i]);
	end

	//////////////////////////////
	// Stage 2
	always_ff @(posedge clk) begin
		result <= sum;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_valid     <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			s1_valid     <= win_valid;
			result_valid <= s1_valid;   // Two cycles after the window
		end
	end

	// Kernel loads never overlap a convolution
	assert property (@(posedge clk) disable iff (!rst_n)
		!(kernel_we && win_valid));

endmodule

// ==== ddr_fetch.sv ====
`timescale 1ns/1ps
`include "cnn_cfg.svh"

module ddr_fetch (
	input  logic                     clk,
	input  logic                     rst_n,
	fetch_cmd_if.unit                cmd,
	output logic                     ddr_conf,
	output cnn_data_pkg::ddr_addr_t  ddr_st_addr,
	output cnn_data_pkg::len_t       ddr_len,
	input  logic                     ddr_fifo_empty,
	output logic                     ddr_fifo_req,
	input  cnn_data_pkg::ddr_word_t  ddr_fifo_data,
	buf_wr_if.src                    wr,
	output logic                     kernel_we,
	output logic [3:0]               kernel_idx,
	output cnn_data_pkg::weight_t    kernel_byte
);

	cnn_ctrl_pkg::fetch_state_e   state;
	cnn_ctrl_pkg::fetch_target_e  target;
	cnn_data_pkg::line_words_t    line_words;
	cnn_data_pkg::len_t           word_cnt;
	logic [1:0]                   bank_cnt;
	cnn_data_pkg::bank_addr_t     addr_cnt;
	logic [3:0]                   k_cnt;      // Next weight index
	cnn_data_pkg::ddr_word_t      k_word;
	cnn_data_pkg::ddr_word_t      k_src;
	logic                         pop;
	logic                         last_word;

	assign pop          = (state == cnn_ctrl_pkg::FET_READ) && !ddr_fifo_empty;
	assign ddr_fifo_req = pop;
	assign last_word    = (word_cnt == cnn_data_pkg::len_t'(ddr_len - 1'b1));
	assign k_src        = pop ? ddr_fifo_data : k_word;

	// Line words go straight to the banks
	assign wr.we   = pop && (target == cnn_ctrl_pkg::TGT_LINES);
	assign wr.bank = bank_cnt;
	assign wr.addr = addr_cnt;
	assign wr.data = ddr_fifo_data;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= cnn_ctrl_pkg::FET_IDLE;
			ddr_conf  <= 1'b0;
			cmd.done  <= 1'b0;
			kernel_we <= 1'b0;
			word_cnt  <= '0;
			bank_cnt  <= '0;
			addr_cnt  <= '0;
			k_cnt     <= '0;
		end else begin
			ddr_conf  <= cmd.start;
			cmd.done  <= pop && last_word;
			kernel_we <= (state == cnn_ctrl_pkg::FET_UNPACK) ||
				(pop && target == cnn_ctrl_pkg::TGT_KERNEL);
			case (state)
				cnn_ctrl_pkg::FET_IDLE: if (cmd.start) state <= cnn_ctrl_pkg::FET_READ;
				cnn_ctrl_pkg::FET_READ: begin
					if (pop && last_word)
						state <= cnn_ctrl_pkg::FET_IDLE;
					else if (pop && target == cnn_ctrl_pkg::TGT_KERNEL)
						state <= cnn_ctrl_pkg::FET_UNPACK;
				end
				cnn_ctrl_pkg::FET_UNPACK: if (k_cnt[2:0] == 3'd7) state <= cnn_ctrl_pkg::FET_READ;
				default: state <= cnn_ctrl_pkg::FET_IDLE;
			endcase
			// Bank and address counters stand in for a divider
			if (cmd.start) begin
				word_cnt <= '0;
				bank_cnt <= '0;
				addr_cnt <= '0;
				k_cnt    <= '0;
			end else if (pop) begin
				word_cnt <= word_cnt + 1'b1;
				if (target == cnn_ctrl_pkg::TGT_KERNEL) begin
					k_cnt <= k_cnt + 1'b1;
				end else if (addr_cnt == cnn_data_pkg::bank_addr_t'(line_words - 1'b1)) begin
					addr_cnt <= '0;
					bank_cnt <= bank_cnt + 1'b1;
				end else begin
					addr_cnt <= addr_cnt + 1'b1;
				end
			end else if (state == cnn_ctrl_pkg::FET_UNPACK) begin
				k_cnt <= k_cnt + 1'b1;
			end
		end
	end

	//////////////////////////////
	// Command fields and kernel bytes
	always_ff @(posedge clk) begin
		if (cmd.start) begin
			target      <= cmd.target;
			line_words  <= cmd.line_words;
			ddr_st_addr <= cmd.ddr_addr;
			ddr_len     <= (cmd.target == cnn_ctrl_pkg::TGT_KERNEL) ?
				cnn_data_pkg::len_t'(`KERNEL_WORDS) : cnn_data_pkg::len_t'(3 * cmd.line_words);
		end
		if (pop)
			k_word <= ddr_fifo_data;
		kernel_idx  <= k_cnt;
		kernel_byte <= k_src[k_cnt[2:0]*`PIX_W +: `PIX_W];   // Byte k mod 8
	end

	// New commands only arrive between reads
	assert property (@(posedge clk) disable iff (!rst_n)
		cmd.start |-> state == cnn_ctrl_pkg::FET_IDLE);

endmodule

// ==== feature_buffer.sv ====
`timescale 1ns/1ps
`include "cnn_cfg.svh"

module feature_buffer (
	input  logic                      clk,
	buf_wr_if.dst                     wr,
	input  cnn_data_pkg::bank_addr_t  rd_addr,
	output cnn_data_pkg::ddr_word_t   rd_data [3]
);

	// One bank per kernel row, all read at the same address
	for (genvar b = 0; b < 3; b++) begin : g_bank
		cnn_data_pkg::ddr_word_t mem [`BANK_DEPTH];

		always_ff @(posedge clk) begin
			if (wr.we && wr.bank == 2'(b))
				mem[wr.addr] <= wr.data;
			rd_data[b] <= mem[rd_addr];   // One cycle read
		end
	end

endmodule

// ==== inst_decoder.sv ====
`timescale 1ns/1ps
`include "cnn_cfg.svh"

module inst_decoder (
	input  logic                       clk,
	input  logic                       rst_n,
	input  cnn_data_pkg::inst_t        instruct,
	input  logic                       inst_empty,
	output logic                       inst_req,
	output logic                       idle,
	fetch_cmd_if.ctrl                  fetch,
	output logic                       scan_start,
	input  logic                       scan_done,
	output cnn_data_pkg::line_words_t  line_words,
	output cnn_data_pkg::bias_t        bias
);

	cnn_ctrl_pkg::dec_state_e  state;
	cnn_ctrl_pkg::opcode_e     opcode;

	assign opcode   = cnn_ctrl_pkg::opcode_e'(instruct[`INST_OP_HI:`INST_OP_LO]);
	assign idle     = (state == cnn_ctrl_pkg::DEC_IDLE);
	assign inst_req = idle && !inst_empty;   // FWFT pop
	assign fetch.line_words = line_words;

	//////////////////////////////
	// Job sequencing
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state       <= cnn_ctrl_pkg::DEC_IDLE;
			fetch.start <= 1'b0;
			scan_start  <= 1'b0;
		end else begin
			fetch.start <= 1'b0;
			scan_start  <= 1'b0;
			case (state)
				cnn_ctrl_pkg::DEC_IDLE: begin
					if (inst_req) begin
						case (opcode)
							cnn_ctrl_pkg::OP_LOAD_W, cnn_ctrl_pkg::OP_LOAD_F: begin
								fetch.start <= 1'b1;
								state       <= cnn_ctrl_pkg::DEC_FETCH;
							end
							cnn_ctrl_pkg::OP_CONV: begin
								scan_start <= 1'b1;
								state      <= cnn_ctrl_pkg::DEC_SCAN;
							end
							default: ;   // NOP retires here
						endcase
					end
				end
				cnn_ctrl_pkg::DEC_FETCH: if (fetch.done) state <= cnn_ctrl_pkg::DEC_IDLE;
				cnn_ctrl_pkg::DEC_SCAN:  if (scan_done) state <= cnn_ctrl_pkg::DEC_IDLE;
				default: state <= cnn_ctrl_pkg::DEC_IDLE;
			endcase
		end
	end

	//////////////////////////////
	// Field capture on the pop edge
	always_ff @(posedge clk) begin
		if (inst_req) begin
			fetch.ddr_addr <= instruct[`INST_ADDR_HI:`INST_ADDR_LO];
			fetch.target   <= (opcode == cnn_ctrl_pkg::OP_LOAD_W) ?
				cnn_ctrl_pkg::TGT_KERNEL : cnn_ctrl_pkg::TGT_LINES;
			if (opcode == cnn_ctrl_pkg::OP_LOAD_F)
				line_words <= instruct[`INST_LW_HI:`INST_LW_LO];   // Kept for later convs
			if (opcode == cnn_ctrl_pkg::OP_CONV)
				bias <= instruct[`INST_BIAS_HI:`INST_BIAS_LO];
		end
	end

	// Done strobes only come back for the job in progress
	assert property (@(posedge clk) disable iff (!rst_n)
		fetch.done |-> state == cnn_ctrl_pkg::DEC_FETCH);
	assert property (@(posedge clk) disable iff (!rst_n)
		scan_done |-> state == cnn_ctrl_pkg::DEC_SCAN);

endmodule

// ==== project.f ====
+incdir+.
cnn_data_pkg.sv
cnn_ctrl_pkg.sv
cnn_if.sv
inst_decoder.sv
ddr_fetch.sv
feature_buffer.sv
window_scanner.sv
conv_pe.sv
cnn_top.sv
tb_cnn_top.sv

// ==== tb_cnn_top.sv ====
`timescale 1ns/1ps
`include "cnn_cfg.svh"

module tb_cnn_top;

	typedef struct packed {
		logic [7:0]                 k_addr;
		logic [7:0]                 f_addr;
		cnn_data_pkg::line_words_t  lw;
		cnn_data_pkg::bias_t        bias;
		logic                       load_w;   // Fetch a new kernel first
		logic                       load_f;   // Fetch new lines first
	} job_t;

	logic                     clk = 1'b0;
	logic                     rst_n;
	cnn_data_pkg::inst_t      instruct;
	logic                     inst_empty;
	logic                     inst_req;
	logic                     ddr_conf;
	cnn_data_pkg::ddr_addr_t  ddr_st_addr;
	cnn_data_pkg::len_t       ddr_len;
	logic                     ddr_fifo_empty;
	logic                     ddr_fifo_req;
	cnn_data_pkg::ddr_word_t  ddr_fifo_data;
	cnn_data_pkg::acc_t       result;
	logic                     result_valid;
	logic                     idle;

	cnn_data_pkg::ddr_word_t  ddr_mem [256];
	job_t                     job_tab [6];
	int                       exp_q [$];        // Pending results in column order
	int                       exp_val;
	cnn_data_pkg::len_t       exp_len;
	cnn_data_pkg::ddr_addr_t  exp_addr;
	logic [7:0]               rd_ptr;
	int                       rd_left = 0;
	int                       cur_k;
	int                       cur_f;
	int                       cur_lw;
	int                       cur_bias;
	int                       check_cnt = 0;
	int                       err_cnt = 0;
	int                       timeout_cnt = 0;
	logic [31:0]              rng = 32'hf268878b;

	cnn_top u_cnn_top (
		.clk(clk), .rst_n(rst_n),
		.instruct(instruct), .inst_empty(inst_empty), .inst_req(inst_req),
		.ddr_conf(ddr_conf), .ddr_st_addr(ddr_st_addr), .ddr_len(ddr_len),
		.ddr_fifo_empty(ddr_fifo_empty), .ddr_fifo_req(ddr_fifo_req),
		.ddr_fifo_data(ddr_fifo_data),
		.result(result), .result_valid(result_valid), .idle(idle)
	);

	always #4 clk = ~clk;   // 8 ns period

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic cnn_data_pkg::inst_t make_inst(input cnn_ctrl_pkg::opcode_e op,
			input cnn_data_pkg::bias_t b, input cnn_data_pkg::line_words_t lw,
			input cnn_data_pkg::ddr_addr_t a);
		cnn_data_pkg::inst_t inst;
		inst = '0;
		inst[`INST_OP_HI:`INST_OP_LO]     = op;
		inst[`INST_BIAS_HI:`INST_BIAS_LO] = b;
		inst[`INST_LW_HI:`INST_LW_LO]     = lw;
		inst[`INST_ADDR_HI:`INST_ADDR_LO] = a;
		return inst;
	endfunction

	// Window at column x over the current lines and kernel
	function automatic int conv_ref(input int x);
		int acc;
		int p;
		int w;
		acc = cur_bias;
		for (int r = 0; r < 3; r++) begin
			for (int c = 0; c < 3; c++) begin
				p = ddr_mem[cur_f + r*cur_lw + (x + c)/8][((x + c)%8)*8 +: 8];
				w = $signed(ddr_mem[cur_k + (3*r + c)/8][((3*r + c)%8)*8 +: 8]);
				acc = acc + p*w;
			end
		end
		return acc;
	endfunction

	task automatic check_bit(input string name, input logic actual, input logic expected);
		check_cnt++;
		assert (actual === expected) else begin
			err_cnt++;
			$display("** Error at %0t: %s expected %0b, got %0b", $time, name, expected, actual);
		end
	endtask

	// Offer one instruction and hold it until it is popped
	task automatic issue_inst(input cnn_data_pkg::inst_t inst);
		int n;
		n = 0;
		instruct   <= inst;
		inst_empty <= 1'b0;
		do begin
			@(posedge clk);
			n++;
		end while (!inst_req && n < 50);
		if (!inst_req) begin
			timeout_cnt++;
			$display("Timeout at %0t: the instruction was never popped", $time);
		end
		inst_empty <= 1'b1;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!idle && n < 2000);
		if (!idle) begin
			timeout_cnt++;
			$display("Timeout at %0t: the DUT did not return to idle", $time);
		end
	endtask

	task automatic wait_results();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < 50) begin
			@(posedge clk);
			n++;
		end
		if (exp_q.size() != 0) begin
			timeout_cnt++;
			$display("Timeout at %0t: %0d results never arrived", $time, exp_q.size());
			exp_q.delete();
		end
	endtask

	//////////////////////////////
	// DDR read FIFO, first word fall through with random gaps
	always @(posedge clk) begin
		if (ddr_conf) begin
			check_cnt += 2;
			assert (ddr_len == exp_len) else begin
				err_cnt++;
				$display("** Error at %0t: ddr_len expected %0d, got %0d",
					$time, exp_len, ddr_len);
			end
			assert (ddr_st_addr == exp_addr) else begin
				err_cnt++;
				$display("** Error at %0t: ddr_st_addr expected %0h, got %0h",
					$time, exp_addr, ddr_st_addr);
			end
			rd_ptr  = ddr_st_addr[7:0];
			rd_left = ddr_len;
		end else if (ddr_fifo_req) begin
			rd_ptr  = rd_ptr + 1'b1;
			rd_left = rd_left - 1;
		end
		ddr_fifo_empty <= (rd_left == 0) || (next_rand() % 4 == 0);
		ddr_fifo_data  <= ddr_mem[rd_ptr];
	end

	// Result monitor, checked in arrival order
	always @(posedge clk) begin
		if (rst_n && result_valid) begin
			if (exp_q.size() == 0) begin
				err_cnt++;
				$display("Unexpected result at %0t with no window pending", $time);
			end else begin
				exp_val = exp_q.pop_front();
				check_cnt++;
				assert (result == exp_val) else begin
					err_cnt++;
					$display("** Error at %0t: result expected %0d, got %0d",
						$time, exp_val, result);
				end
			end
		end
	end

	//////////////////////////////
	// Main sequence
	initial begin
		rst_n          = 1'b0;
		instruct       = '0;
		inst_empty     = 1'b1;
		ddr_fifo_empty = 1'b1;
		ddr_fifo_data  = '0;
		for (int i = 0; i < 256; i++)
			ddr_mem[i] = {next_rand(), next_rand()};

		// Kernel, lines, width, bias, reload kernel, reload lines
		job_tab[0] = '{8'h00, 8'h10, 5'd1,  16'sd100,    1'b1, 1'b1};
		job_tab[1] = '{8'h00, 8'h20, 5'd2,  -16'sd5,     1'b0, 1'b1};
		job_tab[2] = '{8'h02, 8'h40, 5'd16, -16'sd1234,  1'b1, 1'b1};
		job_tab[3] = '{8'h04, 8'h40, 5'd16, -16'sd300,   1'b1, 1'b0};   // Lines reused
		job_tab[4] = '{8'h06, 8'h80, 5'd3,  -16'sd32000, 1'b1, 1'b1};
		job_tab[5] = '{8'h08, 8'h90, 5'd8,  16'sd2047,   1'b1, 1'b1};

		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		// Quiet outputs with an empty queue
		repeat (8) begin
			@(posedge clk);
			check_bit("inst_req", inst_req, 1'b0);
			check_bit("ddr_conf", ddr_conf, 1'b0);
			check_bit("ddr_fifo_req", ddr_fifo_req, 1'b0);
			check_bit("result_valid", result_valid, 1'b0);
			check_bit("idle", idle, 1'b1);
		end

		issue_inst(make_inst(cnn_ctrl_pkg::OP_NOP, '0, '0, '0));
		wait_idle();

		for (int j = 0; j < 6; j++) begin
			if (job_tab[j].load_w) begin
				exp_len  = 16'd2;
				exp_addr = 32'(job_tab[j].k_addr);
				issue_inst(make_inst(cnn_ctrl_pkg::OP_LOAD_W, '0, '0, exp_addr));
				wait_idle();
				cur_k = job_tab[j].k_addr;
			end
			if (job_tab[j].load_f) begin
				exp_len  = 16'(3 * job_tab[j].lw);
				exp_addr = 32'(job_tab[j].f_addr);
				issue_inst(make_inst(cnn_ctrl_pkg::OP_LOAD_F, '0, job_tab[j].lw, exp_addr));
				wait_idle();
				cur_f  = job_tab[j].f_addr;
				cur_lw = job_tab[j].lw;
			end
			cur_bias = job_tab[j].bias;
			for (int x = 0; x < 8*cur_lw - 2; x++)
				exp_q.push_back(conv_ref(x));
			issue_inst(make_inst(cnn_ctrl_pkg::OP_CONV, job_tab[j].bias, '0, '0));
			wait_idle();
			wait_results();
		end

		repeat (10) @(posedge clk);   // Catch stray results
		$display("Checks %0d, errors %0d, timeouts %0d", check_cnt, err_cnt, timeout_cnt);
		if (err_cnt == 0 && timeout_cnt == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== window_scanner.sv ====
`timescale 1ns/1ps
`include "cnn_cfg.svh"

module window_scanner (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       scan_start,
	input  cnn_data_pkg::line_words_t  line_words,
	output cnn_data_pkg::bank_addr_t   rd_addr,
	input  cnn_data_pkg::ddr_word_t    rd_data [3],
	output logic                       win_valid,
	output cnn_data_pkg::pixel_t       window [9],
	output logic                       scan_done
);

	cnn_ctrl_pkg::scan_state_e  state;
	cnn_data_pkg::col_t         col;
	cnn_data_pkg::col_t         last_col;
	logic                       rd_v;       // Bank data valid this cycle
	logic                       rd_last;
	logic                       win_last;
	logic [2:0]                 byte_sel;
	logic [1:0]                 fill;       // Columns held, saturates at 2

	assign last_col = cnn_data_pkg::col_t'({line_words, 3'b000} - 1'b1);
	assign rd_addr  = cnn_data_pkg::bank_addr_t'(col >> 3);   // Word col/8

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= cnn_ctrl_pkg::SCAN_IDLE;
			col       <= '0;
			rd_v      <= 1'b0;
			rd_last   <= 1'b0;
			fill      <= '0;
			win_valid <= 1'b0;
			win_last  <= 1'b0;
			scan_done <= 1'b0;
		end else begin
			rd_v      <= (state == cnn_ctrl_pkg::SCAN_RUN);
			rd_last   <= (state == cnn_ctrl_pkg::SCAN_RUN) && (col == last_col);
			win_valid <= rd_v && (fill == 2'd2);
			win_last  <= rd_v && rd_last;
			scan_done <= win_last;   // Last window has left
			if (scan_start)
				fill <= '0;
			else if (rd_v && fill != 2'd2)
				fill <= fill + 1'b1;
			case (state)
				cnn_ctrl_pkg::SCAN_IDLE: begin
					if (scan_start) begin
						col   <= '0;
						state <= cnn_ctrl_pkg::SCAN_RUN;
					end
				end
				default: begin
					if (col == last_col)
						state <= cnn_ctrl_pkg::SCAN_IDLE;
					else
						col <= col + 1'b1;
				end
			endcase
		end
	end

	//////////////////////////////
	// Column shift, oldest column at c = 0
	always_ff @(posedge clk) begin
		byte_sel <= col[2:0];
		if (rd_v) begin
			for (int r = 0; r < 3; r++) begin
				window[3*r]     <= window[3*r + 1];
				window[3*r + 1] <= window[3*r + 2];
				window[3*r + 2] <= rd_data[r][byte_sel*`PIX_W +: `PIX_W];
			end
		end
	end

endmodule
